// File: rtl/x25519_defs.svh
`ifndef X25519_DEFS_SVH
`define X25519_DEFS_SVH

// field element geometry.
// p = 2^255 - 19, held as 32 little-endian limbs.
`define FE_LIMBS 32
`define LIMB_W 8

// one product column.
// worst case is 32 terms of 38 * 255 * 255, just under 2^27.
`define COL_W 32

// wraparound weights.
// limb 32 sits at 2^256, which is 38 mod p.
`define FOLD_MUL 38
// bit 255 sits at 2^255, which is 19 mod p.
`define REDUCE_MUL 19

`endif

// File: rtl/x25519_pkg.sv
`include "x25519_defs.svh"

package x25519_pkg;

	// field element, limb 0 is least significant.
	typedef logic [`FE_LIMBS-1:0][`LIMB_W-1:0] fe_t;

	// limb or column number, 0 to 31.
	typedef logic [$clog2(`FE_LIMBS)-1:0] limb_idx_t;

	// unreduced column sum.
	typedef logic [`COL_W-1:0] column_t;

	// column pass unit.
	typedef enum logic {
		pass_idle,       // waiting for pass_en.
		pass_accumulate  // one mac per cycle.
	} pass_state_t;

	// streaming reduction.
	typedef enum logic [1:0] {
		sq_collect,      // first carry pass, one column per col_valid.
		sq_fold,         // carry above bit 255 times 19.
		sq_second_pass,  // ripple the folded carry through the limbs.
		sq_done          // result ready for one cycle.
	} squeeze_state_t;

endpackage

// File: rtl/x25519_mult_pass.sv
`include "x25519_defs.svh"

// one output column of a*b per pass.
// column i = sum of a[j]*b[i-j] for j <= i, plus 38*a[j]*b[i+32-j] for j > i.
// the wrapped terms carry 38 because limb 32 is 2^256, which is 38 mod p.
module x25519_mult_pass import x25519_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic pass_en,        // one-cycle start of a pass.
	input limb_idx_t col_idx,   // column to compute.
	input fe_t a,
	input fe_t b,
	output logic col_valid,     // one-cycle pulse with col_sum.
	output column_t col_sum
);

	pass_state_t state;

	limb_idx_t col_i;   // column latched at pass start.
	limb_idx_t j;       // index into a.
	limb_idx_t b_idx;   // matching index into b.
	logic last_term;    // j on its final value.

	logic [2*`LIMB_W-1:0] prod;   // raw limb product.
	column_t term;                // product with wrap weight applied.
	column_t acc;                 // running column sum.
	column_t acc_next;

	// i-j in 5 bits wraps to i+32-j once j passes i.
	// so one subtractor covers both halves of the column.
	assign b_idx = col_i - j;

	assign prod = a[j] * b[b_idx];

	// terms past the diagonal land at limb i+32.
	assign term = (j > col_i) ?
		column_t'(prod) * column_t'(`FOLD_MUL) :
		column_t'(prod);

	assign acc_next = acc + term;

	assign last_term = (j == limb_idx_t'(`FE_LIMBS - 1));

	// control.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= pass_idle;
			j <= '0;
			col_valid <= 1'b0;
		end else begin
			col_valid <= 1'b0;   // pulse by default.
			case (state)
				pass_idle: begin
					if (pass_en) begin
						state <= pass_accumulate;
						j <= '0;
					end
				end
				pass_accumulate: begin
					j <= j + 1'b1;   // wraps to 0 after the last term.
					if (last_term) begin
						// 32 terms done, column registered this edge.
						state <= pass_idle;
						col_valid <= 1'b1;
					end
				end
				default: begin
					state <= pass_idle;
				end
			endcase
		end
	end

	// datapath.
	always_ff @(posedge clk) begin
		if (state == pass_idle && pass_en) begin
			acc <= '0;
			col_i <= col_idx;   // held for all 32 terms.
		end else if (state == pass_accumulate) begin
			acc <= acc_next;
			if (last_term)
				col_sum <= acc_next;   // output register.
		end
	end

endmodule

// File: rtl/x25519_streaming_squeeze.sv
`include "x25519_defs.svh"

// turns 32 raw columns into a 256-bit value congruent to a*b mod p.
// first carry pass runs while columns stream in.
// the carry above bit 255 is then folded back with weight 19.
// a second carry pass ripples that fold through the limbs.
// the result is not frozen below p.
module x25519_streaming_squeeze import x25519_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,       // new operation, clears the column count.
	input logic col_valid,   // next column present.
	input column_t col_sum,
	output logic out_valid,  // one-cycle pulse.
	output fe_t out          // limbs, held after out_valid.
);

	squeeze_state_t state;

	// column number in collect, limb number in second pass.
	limb_idx_t idx;
	logic idx_last;

	// carry into the current limb.
	// after the first pass it is below 2^21, after the fold below 2^26.
	column_t carry;

	column_t col_total;    // incoming column plus carry.
	column_t limb_total;   // current limb plus carry.

	assign idx_last = (idx == limb_idx_t'(`FE_LIMBS - 1));

	assign col_total = col_sum + carry;
	assign limb_total = column_t'(out[idx]) + carry;

	assign out_valid = (state == sq_done);

	// control.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= sq_collect;
			idx <= '0;
		end else if (start) begin
			state <= sq_collect;
			idx <= '0;
		end else begin
			case (state)
				sq_collect: begin
					// columns come in order, one per col_valid.
					if (col_valid) begin
						idx <= idx + 1'b1;
						if (idx_last)
							state <= sq_fold;
					end
				end
				sq_fold: begin
					idx <= '0;   // second pass from limb 0.
					state <= sq_second_pass;
				end
				sq_second_pass: begin
					idx <= idx + 1'b1;
					if (idx_last)
						state <= sq_done;
				end
				sq_done: begin
					// single cycle, out keeps its value.
					state <= sq_collect;
				end
				default: begin
					state <= sq_collect;
				end
			endcase
		end
	end

	// limbs and carry.
	always_ff @(posedge clk) begin
		if (start) begin
			carry <= '0;
		end else begin
			case (state)
				sq_collect: begin
					if (col_valid) begin
						if (idx_last) begin
							// limb 31 keeps bits 248..254 only.
							out[idx] <= {1'b0, col_total[`LIMB_W-2:0]};
							carry <= col_total >> (`LIMB_W - 1);   // weight 2^255.
						end else begin
							out[idx] <= col_total[`LIMB_W-1:0];
							carry <= col_total >> `LIMB_W;
						end
					end
				end
				sq_fold: begin
					// 2^255 = 19 mod p.
					carry <= carry * column_t'(`REDUCE_MUL);
				end
				sq_second_pass: begin
					if (idx_last) begin
						// top limb is below 128 and the carry is 0 or 1 here.
						out[idx] <= out[idx] + carry[`LIMB_W-1:0];
					end else begin
						out[idx] <= limb_total[`LIMB_W-1:0];
						carry <= limb_total >> `LIMB_W;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// File: rtl/x25519_mult.sv
`include "x25519_defs.svh"

// x25519 field multiply, out = a*b mod p (not fully reduced).
// not pipelined; a and b stay stable from en until out_valid.
// 32 column passes feed the squeeze as they finish.
module x25519_mult import x25519_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,          // one-cycle start, ignored while busy.
	input fe_t a,
	input fe_t b,
	output logic busy,
	output logic out_valid,  // one-cycle pulse.
	output fe_t out          // held until the next accepted en.
);

	logic start;   // accepted en.

	// pass sequencing.
	logic pass_en;
	limb_idx_t col_idx;

	// column stream.
	logic col_valid;
	column_t col_sum;

	assign start = en && !busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			pass_en <= 1'b0;
			col_idx <= '0;
		end else begin
			pass_en <= 1'b0;

			if (start) begin
				busy <= 1'b1;
				pass_en <= 1'b1;   // first column.
				col_idx <= '0;
			end else if (out_valid) begin
				busy <= 1'b0;   // low from the cycle after the result.
			end

			// next column one cycle after the last one lands.
			if (col_valid) begin
				col_idx <= col_idx + 1'b1;
				if (col_idx != limb_idx_t'(`FE_LIMBS - 1))
					pass_en <= 1'b1;
			end
		end
	end

	x25519_mult_pass u_pass (
		.clk(clk),
		.rst_n(rst_n),
		.pass_en(pass_en),
		.col_idx(col_idx),
		.a(a),
		.b(b),
		.col_valid(col_valid),
		.col_sum(col_sum)
	);

	// squeeze keeps its own column count.
	x25519_streaming_squeeze u_squeeze (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.col_valid(col_valid),
		.col_sum(col_sum),
		.out_valid(out_valid),
		.out(out)
	);

endmodule

// File: tb/x25519_mult_asserts.sv
// protocol checks for the field multiplier, bound into the top level.
module x25519_mult_asserts import x25519_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic out_valid,
	input logic pass_en,
	input pass_state_t pass_state   // state of the column pass unit.
);

	timeunit 1ns;
	timeprecision 1ps;

	// result is a single-cycle pulse.
	out_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid high for two cycles in a row");

	// no result outside an operation.
	out_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> busy)
		else $error("out_valid while busy is low");

	busy_release: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !busy)
		else $error("busy still high in the cycle after out_valid");

	// a pass may only start from idle.
	pass_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!(pass_en && pass_state == pass_accumulate))
		else $error("pass_en while the pass unit is accumulating");

endmodule

bind x25519_mult x25519_mult_asserts u_asserts (
	.clk(clk),
	.rst_n(rst_n),
	.busy(busy),
	.out_valid(out_valid),
	.pass_en(pass_en),
	.pass_state(u_pass.state)
);

// File: tb/x25519_mult_tb.sv
// directed tests for the x25519 field multiplier.
module x25519_mult_tb import x25519_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;
	localparam int N_OPS = 31;          // 30 operations plus the quiet window.
	localparam int CYCLES_PER_OP = 1200;
	localparam logic [511:0] P = (512'd1 << 255) - 512'd19;   // 2^255 - 19.

	logic clk;
	logic rst_n;
	logic en;
	fe_t a;
	fe_t b;
	logic busy;
	logic out_valid;
	fe_t out;

	int errors;
	int checks;
	int op_latency;          // negedges from en to out_valid, last operation.
	logic [63:0] rng_state;

	x25519_mult DUT (
		.clk(clk),
		.rst_n(rst_n),
		.en(en),
		.a(a),
		.b(b),
		.busy(busy),
		.out_valid(out_valid),
		.out(out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period.
	end

	// run length is bounded by the number of operations.
	initial begin
		repeat (RESET_CYCLES + N_OPS * CYCLES_PER_OP) @(posedge clk);
		$display("timeout: the tests did not finish in %0d cycles",
			RESET_CYCLES + N_OPS * CYCLES_PER_OP);
		$display("=== FAIL ===");
		$finish;
	end

	// 64-bit xorshift.
	function automatic logic [63:0] xorshift64();
		logic [63:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		rng_state = x;
		return x;
	endfunction

	function automatic fe_t random_fe();
		return {xorshift64(), xorshift64(), xorshift64(), xorshift64()};
	endfunction

	// a*b mod p, full width.
	function automatic logic [511:0] mod_mul(input fe_t x, input fe_t y);
		logic [511:0] prod;
		prod = {256'd0, x} * {256'd0, y};
		return prod % P;
	endfunction

	// one operation; optional second en at cycle extra_en_at (0 for none).
	task automatic run_op(input fe_t x, input fe_t y, input int extra_en_at,
			output fe_t res);
		int cycles;
		@(negedge clk);
		a = x;
		b = y;
		en = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			en = (cycles == extra_en_at);
			if (cycles == extra_en_at) begin
				checks++;
				assert (busy) else begin
					errors++;
					$display("ERR %0t: busy low when the second en was pulsed", $time);
				end
			end
		end while (!out_valid);
		en = 1'b0;
		res = out;   // a and b stay put until the next operation.
		op_latency = cycles;
	endtask

	task automatic check_exact(input fe_t x, input fe_t y, input string name);
		fe_t res;
		logic [511:0] expected;
		expected = {256'd0, x} * {256'd0, y};
		run_op(x, y, 0, res);
		checks++;
		assert (res == expected[255:0]) else begin
			errors++;
			$display("ERR %0t: %s: out %h, expected %h", $time, name, res,
				expected[255:0]);
		end
	endtask

	task automatic check_congruent(input fe_t x, input fe_t y, input int extra_en_at,
			input string name);
		fe_t res;
		logic [511:0] expected;
		expected = mod_mul(x, y);
		run_op(x, y, extra_en_at, res);
		checks++;
		assert (({256'd0, res} % P) == expected) else begin
			errors++;
			$display("ERR %0t: %s: out %h not congruent to %h mod p", $time, name,
				res, expected[255:0]);
		end
	endtask

	task automatic test_reset_idle();
		repeat (8) begin
			@(negedge clk);
			checks++;
			assert (!out_valid && !busy) else begin
				errors++;
				$display("ERR %0t: out_valid %b busy %b after reset", $time,
					out_valid, busy);
			end
		end
	endtask

	// products below 2^255 need no reduction.
	task automatic test_small();
		fe_t x;
		logic [255:0] y;   // flat bits for the 100-bit operand.
		check_exact('0, random_fe(), "zero times x");
		x = random_fe();
		x[31][7] = 1'b0;   // keep x below 2^255.
		check_exact(fe_t'(1), x, "one times x");
		check_exact(fe_t'(3), fe_t'(5), "three times five");
		x = random_fe();
		y = random_fe();
		check_exact({128'd0, x[15:0]}, {156'd0, y[99:0]}, "128 by 100 bits");
	endtask

	task automatic test_near_modulus();
		fe_t pm1;
		pm1 = P[255:0] - 256'd1;
		check_congruent(pm1, pm1, 0, "p-1 squared");   // expected 1.
		check_congruent('1, '1, 0, "all ones squared");
	endtask

	task automatic test_random();
		repeat (20) check_congruent(random_fe(), random_fe(), 0, "random pair");
	endtask

	// each run_op starts at the negedge after the previous out_valid.
	task automatic test_back_to_back();
		repeat (3) check_congruent(random_fe(), random_fe(), 0, "back to back");
	endtask

	task automatic test_busy_en_ignored();
		int ref_latency;
		int pulses;
		ref_latency = op_latency;   // a restart would lengthen the operation.
		check_congruent(random_fe(), random_fe(), 10, "en while busy");
		checks++;
		assert (op_latency == ref_latency) else begin
			errors++;
			$display("ERR %0t: latency %0d with a second en, %0d without", $time,
				op_latency, ref_latency);
		end
		pulses = 0;
		repeat (100) begin
			@(negedge clk);
			if (out_valid)
				pulses++;
		end
		checks++;
		assert (pulses == 0) else begin
			errors++;
			$display("ERR %0t: %0d extra out_valid pulses after the result", $time, pulses);
		end
	endtask

	initial begin
		rng_state = 64'd92;
		errors = 0;
		checks = 0;
		op_latency = 0;
		rst_n = 1'b0;
		en = 1'b0;
		a = '0;
		b = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		test_reset_idle();
		test_small();
		test_near_modulus();
		test_random();
		test_back_to_back();
		test_busy_en_ignored();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: sources.f
+incdir+rtl
rtl/x25519_pkg.sv
rtl/x25519_mult_pass.sv
rtl/x25519_streaming_squeeze.sv
rtl/x25519_mult.sv
tb/x25519_mult_asserts.sv
tb/x25519_mult_tb.sv

// File: Makefile
TOP = x25519_mult_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
